//--- common/xip_pkg.sv
`default_nettype none

package xip_pkg;

    localparam int XIP_ADDR_W = 24; // 16 MB flash window

    // AHB transfer type
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    // AHB transfer size, wider sizes are not used on a 32-bit bus
    typedef enum logic [2:0] {
        HSIZE_BYTE = 3'b000,
        HSIZE_HALF = 3'b001,
        HSIZE_WORD = 3'b010
    } hsize_e;

    // standard read, no dummy cycles
    typedef enum logic [7:0] {
        FLASH_READ = 8'h03
    } flash_opcode_e;

    typedef enum logic [2:0] {
        SPI_IDLE = 3'd0,
        SPI_CMD  = 3'd1,
        SPI_ADDR = 3'd2,
        SPI_DATA = 3'd3,
        SPI_GAP  = 3'd4 // trailing edge and deselect time
    } spi_state_e;

    typedef struct packed {
        logic [XIP_ADDR_W-1:0] addr;      // flash byte address
        logic [1:0]            nbytes_m1; // 0..3 means 1..4 bytes
        logic [1:0]            lane;      // lane of the first byte
    } xip_rd_cmd_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last; // final byte of the command
    } xip_byte_t;

endpackage

`default_nettype wire

//--- hdl/ahb_xip_decode.sv
`default_nettype none

module ahb_xip_decode #(
    parameter bit en_unaligned = 1'b0,
    parameter bit en_narrow    = 1'b0
)(
    input  wire                   amba_clk,
    input  wire                   amba_resetn,
    input  wire                   ahb_hsel_i,
    input  wire [31:0]            ahb_haddr_i,
    input  wire xip_pkg::htrans_e ahb_htrans_i,
    input  wire xip_pkg::hsize_e  ahb_hsize_i,
    input  wire                   ahb_hwrite_i,
    input  wire                   ahb_hready_i,
    input  wire                   en_xip_i,
    output xip_pkg::xip_rd_cmd_t  rd_cmd_o,
    output logic                  rd_cmd_vld_o,
    output logic                  err_req_o,
    output logic [1:0]            xip_err_o
);

    logic       accept;
    logic       rd_ok;
    logic       wrong_align;
    logic       wrong_size;
    logic [1:0] nbytes_m1;
    logic [1:0] lane;

    assign accept = ahb_hsel_i & ahb_hready_i & ahb_htrans_i[1]; // nonseq or seq
    assign rd_ok = accept & ~ahb_hwrite_i & en_xip_i;

    // only flagged in the modes that cannot serve them
    assign wrong_align = !en_unaligned && (ahb_haddr_i[1:0] != 2'b00);
    assign wrong_size = !en_narrow && (ahb_hsize_i != xip_pkg::HSIZE_WORD);

    // byte count and first lane per mode
    always_comb
    begin
        if (!en_unaligned)
        begin
            lane = 2'd0;
            case (ahb_hsize_i)
                xip_pkg::HSIZE_BYTE: nbytes_m1 = 2'd0;
                xip_pkg::HSIZE_HALF: nbytes_m1 = 2'd1;
                default:             nbytes_m1 = 2'd3;
            endcase
        end
        else if (!en_narrow)
        begin
            lane = ahb_haddr_i[1:0];
            nbytes_m1 = ~ahb_haddr_i[1:0]; // up to the word boundary
        end
        else
        begin
            lane = ahb_haddr_i[1:0];
            case (ahb_hsize_i)
                xip_pkg::HSIZE_BYTE: nbytes_m1 = 2'd0;
                xip_pkg::HSIZE_HALF: nbytes_m1 = (ahb_haddr_i[1:0] == 2'b11) ? 2'd0 : 2'd1;
                default:             nbytes_m1 = ~ahb_haddr_i[1:0];
            endcase
        end
    end

    always_ff @(posedge amba_clk or negedge amba_resetn)
    begin
        if (!amba_resetn)
        begin
            rd_cmd_vld_o <= 1'b0;
            err_req_o <= 1'b0;
            xip_err_o <= 2'b00;
        end
        else
        begin
            rd_cmd_vld_o <= rd_ok;
            err_req_o <= accept & (ahb_hwrite_i | ~en_xip_i); // read-only port
            xip_err_o[1] <= accept & ~ahb_hwrite_i & wrong_align;
            xip_err_o[0] <= accept & ~ahb_hwrite_i & wrong_size;
        end
    end

    // held until the next read is accepted
    always_ff @(posedge amba_clk)
    begin
        if (rd_ok)
        begin
            rd_cmd_o.addr <= ahb_haddr_i[xip_pkg::XIP_ADDR_W-1:0];
            rd_cmd_o.nbytes_m1 <= nbytes_m1;
            rd_cmd_o.lane <= lane;
        end
    end

    // the stalled data phase keeps a second request out
    a_one_request: assert property (@(posedge amba_clk) disable iff (!amba_resetn)
        (rd_cmd_vld_o || err_req_o) |=> !(rd_cmd_vld_o || err_req_o))
        else $error("two requests in consecutive cycles");

endmodule

`default_nettype wire

//--- spi_xip/spi_xip_engine.sv
`default_nettype none

module spi_xip_engine #(
    parameter int sck_div_n = 4
)(
    input  wire                       amba_clk,
    input  wire                       amba_resetn,
    input  wire xip_pkg::xip_rd_cmd_t rd_cmd_i,
    input  wire                       rd_cmd_vld_i,
    input  wire                       spi_miso_i,
    output xip_pkg::xip_byte_t        rx_byte_o,
    output logic                      rx_byte_vld_o,
    output logic                      spi_ss_o,
    output logic                      spi_sck_o,
    output logic                      spi_mosi_o
);

    localparam int HALF = sck_div_n / 2;
    localparam int DIV_W = (HALF > 1) ? $clog2(HALF) : 1;
    localparam int GAP_N = 2 * sck_div_n; // last fall, hold, then deselect
    localparam int GAP_W = $clog2(GAP_N);

    xip_pkg::spi_state_e state;
    logic [DIV_W-1:0]    div_cnt;
    logic [GAP_W-1:0]    gap_cnt;
    logic [4:0]          bit_cnt;  // falling edges within a phase or byte
    logic [1:0]          byte_cnt;
    logic [31:0]         tx_sh;    // opcode then address, msb first
    logic [6:0]          rx_sh;
    logic                pend;     // command taken during the gap
    logic                tick;
    logic                rise;
    logic                fall;
    logic                gap_end;
    logic                start;

    assign tick = (div_cnt == DIV_W'(HALF - 1));
    assign rise = tick & ~spi_sck_o;
    assign fall = tick & spi_sck_o;
    assign gap_end = (gap_cnt == GAP_W'(GAP_N - 1));
    assign start = ((state == xip_pkg::SPI_IDLE) & rd_cmd_vld_i) |
                   ((state == xip_pkg::SPI_GAP) & gap_end & (pend | rd_cmd_vld_i));
    assign spi_mosi_o = tx_sh[31];

    always_ff @(posedge amba_clk or negedge amba_resetn)
    begin
        if (!amba_resetn)
        begin
            state <= xip_pkg::SPI_IDLE;
            div_cnt <= '0;
            gap_cnt <= '0;
            bit_cnt <= '0;
            byte_cnt <= '0;
            pend <= 1'b0;
            tx_sh <= '0;
            rx_byte_vld_o <= 1'b0;
            spi_ss_o <= 1'b1;
            spi_sck_o <= 1'b0;
        end
        else
        begin
            rx_byte_vld_o <= 1'b0;
            if (start)
            begin
                state <= xip_pkg::SPI_CMD;
                spi_ss_o <= 1'b0; // first bit already on mosi
                div_cnt <= '0;
                bit_cnt <= '0;
                byte_cnt <= '0;
                pend <= 1'b0;
                tx_sh <= {xip_pkg::FLASH_READ, rd_cmd_i.addr};
            end
            else
            begin
                case (state)
                    xip_pkg::SPI_CMD, xip_pkg::SPI_ADDR, xip_pkg::SPI_DATA:
                    begin
                        div_cnt <= tick ? '0 : div_cnt + 1'b1;
                        if (rise)
                        begin
                            spi_sck_o <= 1'b1;
                            if (state == xip_pkg::SPI_DATA && bit_cnt == 5'd7)
                            begin
                                rx_byte_vld_o <= 1'b1;
                                if (byte_cnt == rd_cmd_i.nbytes_m1)
                                begin
                                    state <= xip_pkg::SPI_GAP; // bus can move on now
                                    gap_cnt <= '0;
                                end
                            end
                        end
                        if (fall)
                        begin
                            spi_sck_o <= 1'b0;
                            tx_sh <= {tx_sh[30:0], 1'b0};
                            bit_cnt <= bit_cnt + 1'b1;
                            if (state == xip_pkg::SPI_CMD && bit_cnt == 5'd7)
                            begin
                                state <= xip_pkg::SPI_ADDR;
                                bit_cnt <= '0;
                            end
                            else if (state == xip_pkg::SPI_ADDR && bit_cnt == 5'd23)
                            begin
                                state <= xip_pkg::SPI_DATA;
                                bit_cnt <= '0;
                            end
                            else if (state == xip_pkg::SPI_DATA && bit_cnt == 5'd7)
                            begin
                                bit_cnt <= '0;
                                byte_cnt <= byte_cnt + 1'b1;
                            end
                        end
                    end
                    xip_pkg::SPI_GAP:
                    begin
                        gap_cnt <= gap_cnt + 1'b1;
                        if (gap_cnt == GAP_W'(HALF - 1))
                            spi_sck_o <= 1'b0; // closing falling edge
                        if (gap_cnt == GAP_W'(sck_div_n - 1))
                            spi_ss_o <= 1'b1;
                        if (rd_cmd_vld_i)
                            pend <= 1'b1;
                        if (gap_end)
                            state <= xip_pkg::SPI_IDLE;
                    end
                    default: state <= xip_pkg::SPI_IDLE;
                endcase
            end
        end
    end

    // sampled on the rising edge, mode 0
    always_ff @(posedge amba_clk)
    begin
        if (rise && state == xip_pkg::SPI_DATA)
        begin
            rx_sh <= {rx_sh[5:0], spi_miso_i};
            rx_byte_o.data <= {rx_sh, spi_miso_i};
            rx_byte_o.last <= (byte_cnt == rd_cmd_i.nbytes_m1);
        end
    end

    // hready holds the bus, so no command can land mid-transfer
    a_cmd_when_free: assert property (@(posedge amba_clk) disable iff (!amba_resetn)
        rd_cmd_vld_i |-> (state == xip_pkg::SPI_IDLE || state == xip_pkg::SPI_GAP) && !pend)
        else $error("read command while a flash read is in progress");

    a_ss_around_sck: assert property (@(posedge amba_clk) disable iff (!amba_resetn)
        $changed(spi_sck_o) |-> !spi_ss_o)
        else $error("sck edge with flash deselected");

endmodule

`default_nettype wire

//--- hdl/ahb_xip_response.sv
`default_nettype none

module ahb_xip_response (
    input  wire                       amba_clk,
    input  wire                       amba_resetn,
    input  wire xip_pkg::xip_rd_cmd_t rd_cmd_i,
    input  wire                       rd_cmd_vld_i,
    input  wire                       err_req_i,
    input  wire xip_pkg::xip_byte_t   rx_byte_i,
    input  wire                       rx_byte_vld_i,
    output logic                      ahb_hready_o,
    output logic [31:0]               ahb_hrdata_o,
    output logic                      ahb_hresp_o
);

    logic        hready_q;
    logic        err_q;    // second cycle of ERROR
    logic        rd_pend;
    logic [3:0]  lane_ptr; // one-hot, lane of the next byte
    logic [31:0] asm_q;
    logic [31:0] asm_nxt;

    // the strobes come from registers, so the data phase stalls at once
    assign ahb_hready_o = hready_q & ~rd_cmd_vld_i & ~err_req_i;
    assign ahb_hresp_o = err_req_i | err_q;

    always_comb
    begin
        for (int i = 0; i < 4; i++)
            asm_nxt[8*i +: 8] = lane_ptr[i] ? rx_byte_i.data : asm_q[8*i +: 8];
    end

    always_ff @(posedge amba_clk or negedge amba_resetn)
    begin
        if (!amba_resetn)
        begin
            hready_q <= 1'b1;
            err_q <= 1'b0;
            rd_pend <= 1'b0;
            lane_ptr <= 4'b0000;
        end
        else
        begin
            err_q <= err_req_i;
            if (rd_cmd_vld_i)
            begin
                hready_q <= 1'b0;
                rd_pend <= 1'b1;
                lane_ptr <= 4'b0001 << rd_cmd_i.lane;
            end
            else if (rx_byte_vld_i)
            begin
                lane_ptr <= {lane_ptr[2:0], lane_ptr[3]}; // wraps to lane 0
                if (rx_byte_i.last)
                begin
                    hready_q <= 1'b1;
                    rd_pend <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge amba_clk)
    begin
        if (rd_cmd_vld_i)
            asm_q <= '0;
        else if (rx_byte_vld_i)
        begin
            asm_q <= asm_nxt;
            if (rx_byte_i.last)
                ahb_hrdata_o <= asm_nxt;
        end
    end

    a_byte_in_read: assert property (@(posedge amba_clk) disable iff (!amba_resetn)
        rx_byte_vld_i |-> rd_pend)
        else $error("flash byte without a pending read");

endmodule

`default_nettype wire

//--- hdl/ahb_xip_top.sv
`default_nettype none

module ahb_xip_top #(
    parameter int sck_div_n    = 4,    // even, at least 2
    parameter bit en_unaligned = 1'b1,
    parameter bit en_narrow    = 1'b1
)(
    input  wire                   amba_clk,
    input  wire                   amba_resetn,
    input  wire                   ahb_hsel_i,
    input  wire [31:0]            ahb_haddr_i,
    input  wire xip_pkg::htrans_e ahb_htrans_i,
    input  wire xip_pkg::hsize_e  ahb_hsize_i,
    input  wire                   ahb_hwrite_i,
    input  wire                   ahb_hready_i,
    output logic                  ahb_hready_o,
    output logic [31:0]           ahb_hrdata_o,
    output logic                  ahb_hresp_o,
    input  wire                   en_xip_i,
    output logic                  spi_ss_o,
    output logic                  spi_sck_o,
    output logic                  spi_mosi_o,
    input  wire                   spi_miso_i,
    output logic [1:0]            xip_err_o    // {unaligned, narrow}
);

    xip_pkg::xip_rd_cmd_t rd_cmd;
    logic                 rd_cmd_vld;
    logic                 err_req;
    xip_pkg::xip_byte_t   rx_byte;
    logic                 rx_byte_vld;

    ahb_xip_decode #(
        .en_unaligned (en_unaligned),
        .en_narrow    (en_narrow)
    ) i_decode (
        .amba_clk     (amba_clk),
        .amba_resetn  (amba_resetn),
        .ahb_hsel_i   (ahb_hsel_i),
        .ahb_haddr_i  (ahb_haddr_i),
        .ahb_htrans_i (ahb_htrans_i),
        .ahb_hsize_i  (ahb_hsize_i),
        .ahb_hwrite_i (ahb_hwrite_i),
        .ahb_hready_i (ahb_hready_i),
        .en_xip_i     (en_xip_i),
        .rd_cmd_o     (rd_cmd),
        .rd_cmd_vld_o (rd_cmd_vld),
        .err_req_o    (err_req),
        .xip_err_o    (xip_err_o)
    );

    spi_xip_engine #(
        .sck_div_n (sck_div_n)
    ) i_engine (
        .amba_clk      (amba_clk),
        .amba_resetn   (amba_resetn),
        .rd_cmd_i      (rd_cmd),
        .rd_cmd_vld_i  (rd_cmd_vld),
        .spi_miso_i    (spi_miso_i),
        .rx_byte_o     (rx_byte),
        .rx_byte_vld_o (rx_byte_vld),
        .spi_ss_o      (spi_ss_o),
        .spi_sck_o     (spi_sck_o),
        .spi_mosi_o    (spi_mosi_o)
    );

    ahb_xip_response i_response (
        .amba_clk      (amba_clk),
        .amba_resetn   (amba_resetn),
        .rd_cmd_i      (rd_cmd),
        .rd_cmd_vld_i  (rd_cmd_vld),
        .err_req_i     (err_req),
        .rx_byte_i     (rx_byte),
        .rx_byte_vld_i (rx_byte_vld),
        .ahb_hready_o  (ahb_hready_o),
        .ahb_hrdata_o  (ahb_hrdata_o),
        .ahb_hresp_o   (ahb_hresp_o)
    );

endmodule

`default_nettype wire

//--- dv/spi_flash_model.sv
`default_nettype none

module spi_flash_model (
    input  wire  spi_ss_i,
    input  wire  spi_sck_i,
    input  wire  spi_mosi_i,
    output logic spi_miso_o
);

    int          bit_cnt;   // sck rises since select
    int          data_bit;
    logic [31:0] cmd_sh;    // opcode and address as received
    logic [23:0] byte_addr;
    logic [7:0]  data_byte;

    function automatic logic [7:0] flash_data(input logic [23:0] addr);
        return addr[7:0] ^ addr[15:8] ^ 8'ha5;
    endfunction

    initial
    begin
        bit_cnt = 0;
        cmd_sh = '0;
        spi_miso_o = 1'b0;
    end

    always @(negedge spi_ss_i)
        bit_cnt = 0;

    // mode 0, mosi taken on the rising edge
    always @(posedge spi_sck_i)
    begin
        if (!spi_ss_i)
        begin
            if (bit_cnt < 32)
                cmd_sh = {cmd_sh[30:0], spi_mosi_i};
            bit_cnt = bit_cnt + 1;
        end
    end

    // next data bit goes out on the falling edge
    always @(negedge spi_sck_i)
    begin
        if (!spi_ss_i && bit_cnt >= 32)
        begin
            data_bit = bit_cnt - 32;
            byte_addr = cmd_sh[23:0] + 24'(data_bit / 8); // counts up from the start address
            data_byte = flash_data(byte_addr);
            if (cmd_sh[31:24] == xip_pkg::FLASH_READ)
                spi_miso_o = data_byte[7 - data_bit % 8];
            else
                spi_miso_o = 1'b1; // unknown opcode
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_ahb_xip_top.sv
`default_nettype none

module tb_ahb_xip_top;

    localparam int  sck_div_n      = 4;
    localparam bit  en_unaligned   = 1'b1;
    localparam bit  en_narrow      = 1'b1;
    localparam int  n_xfers        = 17;
    localparam time watchdog_limit = n_xfers * 80 * sck_div_n * 4;

    typedef struct packed {
        logic            write;
        logic            en_xip;
        logic [31:0]     addr;
        xip_pkg::hsize_e hsize;
        logic [1:0]      exp_err; // {unaligned, narrow}
    } xfer_t;

    logic             amba_clk;
    logic             amba_resetn;
    logic             ahb_hsel;
    logic [31:0]      ahb_haddr;
    xip_pkg::htrans_e ahb_htrans;
    xip_pkg::hsize_e  ahb_hsize;
    logic             ahb_hwrite;
    logic             en_xip;
    logic             ahb_hready;
    logic [31:0]      ahb_hrdata;
    logic             ahb_hresp;
    logic             spi_ss;
    logic             spi_sck;
    logic             spi_mosi;
    logic             spi_miso;
    logic [1:0]       xip_err;
    xfer_t            xfers [n_xfers];
    logic [31:0]      lfsr;
    int               errors;
    int               ss_falls;

    // single slave, so bus hready is the slave's own
    ahb_xip_top #(
        .sck_div_n    (sck_div_n),
        .en_unaligned (en_unaligned),
        .en_narrow    (en_narrow)
    ) i_dut (
        .amba_clk     (amba_clk),
        .amba_resetn  (amba_resetn),
        .ahb_hsel_i   (ahb_hsel),
        .ahb_haddr_i  (ahb_haddr),
        .ahb_htrans_i (ahb_htrans),
        .ahb_hsize_i  (ahb_hsize),
        .ahb_hwrite_i (ahb_hwrite),
        .ahb_hready_i (ahb_hready),
        .ahb_hready_o (ahb_hready),
        .ahb_hrdata_o (ahb_hrdata),
        .ahb_hresp_o  (ahb_hresp),
        .en_xip_i     (en_xip),
        .spi_ss_o     (spi_ss),
        .spi_sck_o    (spi_sck),
        .spi_mosi_o   (spi_mosi),
        .spi_miso_i   (spi_miso),
        .xip_err_o    (xip_err)
    );

    spi_flash_model i_flash (
        .spi_ss_i   (spi_ss),
        .spi_sck_i  (spi_sck),
        .spi_mosi_i (spi_mosi),
        .spi_miso_o (spi_miso)
    );

    function automatic xfer_t make_xfer(input logic write, input logic en,
                                        input logic [31:0] addr, input xip_pkg::hsize_e hsize,
                                        input logic [1:0] exp_err);
        xfer_t x;
        x.write = write;
        x.en_xip = en;
        x.addr = addr;
        x.hsize = hsize;
        x.exp_err = exp_err;
        return x;
    endfunction

    function automatic logic [7:0] flash_byte(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ 8'ha5;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic fill_table();
        xfers[0]  = make_xfer(0, 1, 32'h0000_0000, xip_pkg::HSIZE_WORD, 2'b00);
        xfers[1]  = make_xfer(0, 1, 32'h0000_12a4, xip_pkg::HSIZE_WORD, 2'b00);
        xfers[2]  = make_xfer(0, 1, 32'h0000_0310, xip_pkg::HSIZE_BYTE, 2'b00);
        xfers[3]  = make_xfer(0, 1, 32'h0000_0311, xip_pkg::HSIZE_BYTE, 2'b00);
        xfers[4]  = make_xfer(0, 1, 32'h0000_0312, xip_pkg::HSIZE_BYTE, 2'b00);
        xfers[5]  = make_xfer(0, 1, 32'h0000_0313, xip_pkg::HSIZE_BYTE, 2'b00);
        xfers[6]  = make_xfer(0, 1, 32'h0000_a520, xip_pkg::HSIZE_HALF, 2'b00);
        xfers[7]  = make_xfer(0, 1, 32'h0000_a521, xip_pkg::HSIZE_HALF, 2'b00);
        xfers[8]  = make_xfer(0, 1, 32'h0000_a522, xip_pkg::HSIZE_HALF, 2'b00);
        xfers[9]  = make_xfer(0, 1, 32'h0000_a523, xip_pkg::HSIZE_HALF, 2'b00);
        xfers[10] = make_xfer(0, 1, 32'h0000_ff01, xip_pkg::HSIZE_WORD, 2'b00);
        xfers[11] = make_xfer(0, 1, 32'h0000_fffe, xip_pkg::HSIZE_WORD, 2'b00);
        xfers[12] = make_xfer(0, 1, 32'h0001_ffff, xip_pkg::HSIZE_WORD, 2'b00);
        xfers[13] = make_xfer(1, 1, 32'h0000_0040, xip_pkg::HSIZE_WORD, 2'b00); // write
        xfers[14] = make_xfer(0, 0, 32'h0000_0080, xip_pkg::HSIZE_WORD, 2'b00); // xip off
        xfers[15] = make_xfer(0, 1, 32'h00ff_fffc, xip_pkg::HSIZE_WORD, 2'b00); // top of flash
        xfers[16] = make_xfer(0, 1, 32'h0000_0ff0, xip_pkg::HSIZE_WORD, 2'b00);
    endtask

    // one lfsr step per gap bit, gap of 0 to 3 cycles
    task automatic next_gap(output int gap);
        gap = 0;
        for (int b = 0; b < 2; b++)
        begin
            lfsr = lfsr_step(lfsr);
            gap = (gap << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic predict_read(input logic [31:0] addr, input xip_pkg::hsize_e hsize,
                                output logic [31:0] data, output logic [31:0] mask);
        int n;
        int first;
        data = '0;
        mask = '0;
        first = en_unaligned ? int'(addr[1:0]) : 0;
        if (!en_unaligned)
            n = (hsize == xip_pkg::HSIZE_BYTE) ? 1 : (hsize == xip_pkg::HSIZE_HALF) ? 2 : 4;
        else if (!en_narrow || hsize == xip_pkg::HSIZE_WORD)
            n = 4 - int'(addr[1:0]);
        else if (hsize == xip_pkg::HSIZE_BYTE)
            n = 1;
        else
            n = (addr[1:0] == 2'b11) ? 1 : 2;
        for (int k = 0; k < n; k++)
        begin
            data[8*((first + k) % 4) +: 8] = flash_byte(addr[23:0] + 24'(k));
            mask[8*((first + k) % 4) +: 8] = 8'hff;
        end
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected)
        begin
            errors++;
            $display("[ERROR] %0t: %s, got %h, expected %h", $time, what, got, expected);
        end
    endtask

    initial
    begin
        amba_clk = 1'b0;
        forever #2 amba_clk = ~amba_clk;
    end

    always @(negedge spi_ss)
        if (amba_resetn)
            ss_falls++;

    initial
    begin
        #(watchdog_limit);
        $display("watchdog expired, a transfer did not complete in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        xfer_t       x;
        logic [31:0] exp_data;
        logic [31:0] mask;
        logic        is_err;
        int          gap;
        int          cycles;
        int          falls_before;

        errors = 0;
        ss_falls = 0;
        lfsr = 32'h38fa;
        amba_resetn = 1'b0;
        ahb_hsel = 1'b0;
        ahb_haddr = '0;
        ahb_htrans = xip_pkg::HTRANS_IDLE;
        ahb_hsize = xip_pkg::HSIZE_WORD;
        ahb_hwrite = 1'b0;
        en_xip = 1'b1;
        fill_table();
        repeat (3) @(posedge amba_clk);
        amba_resetn <= 1'b1;
        @(negedge amba_clk);
        check_value(ahb_hready, 1, "hready after reset");
        check_value(ahb_hresp, 0, "hresp after reset");
        check_value(spi_ss, 1, "spi select after reset");
        check_value(spi_sck, 0, "sck after reset");

        for (int i = 0; i < n_xfers; i++)
        begin
            x = xfers[i];
            is_err = x.write | ~x.en_xip;
            next_gap(gap);
            repeat (gap) @(posedge amba_clk);
            @(posedge amba_clk);
            ahb_hsel <= 1'b1; // address phase
            ahb_htrans <= xip_pkg::HTRANS_NONSEQ;
            ahb_haddr <= x.addr;
            ahb_hsize <= x.hsize;
            ahb_hwrite <= x.write;
            en_xip <= x.en_xip;
            falls_before = ss_falls;
            @(posedge amba_clk);
            ahb_hsel <= 1'b0;
            ahb_htrans <= xip_pkg::HTRANS_IDLE;
            @(negedge amba_clk);
            check_value(ahb_hready, 0, $sformatf("xfer %0d hready in first data cycle", i));
            check_value(ahb_hresp, is_err, $sformatf("xfer %0d hresp in first data cycle", i));
            check_value(xip_err, x.exp_err, $sformatf("xfer %0d error flags", i));
            cycles = 1;
            while (!ahb_hready)
            begin
                @(negedge amba_clk);
                cycles++;
            end
            check_value(ahb_hresp, is_err, $sformatf("xfer %0d hresp at completion", i));
            if (is_err)
            begin
                check_value(cycles, 2, $sformatf("xfer %0d error response length", i));
                check_value(ss_falls - falls_before, 0, $sformatf("xfer %0d spi select", i));
            end
            else
            begin
                predict_read(x.addr, x.hsize, exp_data, mask);
                check_value(ahb_hrdata & mask, exp_data, $sformatf("xfer %0d read data", i));
                check_value(ss_falls - falls_before, 1, $sformatf("xfer %0d spi select", i));
            end
            @(negedge amba_clk);
            check_value(ahb_hresp, 0, $sformatf("xfer %0d hresp after data phase", i));
            check_value(xip_err, 2'b00, $sformatf("xfer %0d error flags cleared", i));
        end

        $display("run complete with %0d errors", errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- ahb_xip_top.f
common/xip_pkg.sv
hdl/ahb_xip_decode.sv
spi_xip/spi_xip_engine.sv
hdl/ahb_xip_response.sv
hdl/ahb_xip_top.sv
dv/spi_flash_model.sv
dv/tb_ahb_xip_top.sv
